/* logic/rs_pkg.sv */
package rs_pkg;

  localparam int scalar  = 2;  // Lanes and banks
  localparam int prf_idx = 6;
  localparam int rob_idx = 5;
  localparam int lsq_idx = 3;
  localparam int rs_sz   = 8;  // Entries per bank
  localparam int rs_idx  = 3;
  localparam int op_w    = 5;
  localparam int ir_w    = 32;
  localparam int pc_w    = 64;
  localparam int cls_w   = 2;

  localparam logic [op_w-1:0] op_mult = 5'h0d;

  // Unit classes.
  // Memory when rd_mem or wr_mem is set, multiply when a non-memory op
  // carries op_mult, ALU for everything else
  localparam logic [cls_w-1:0] cls_alu  = 2'd0;
  localparam logic [cls_w-1:0] cls_mem  = 2'd1;
  localparam logic [cls_w-1:0] cls_mult = 2'd2;

  function automatic logic [cls_w-1:0] fu_class_of(input logic [op_w-1:0] op,
                                                   input logic rd,
                                                   input logic wr);
    if (rd || wr) begin
      return cls_mem;
    end
    if (op == op_mult) begin
      return cls_mult;
    end
    return cls_alu;
  endfunction

endpackage

/* logic/rs_entry.sv */
`timescale 1ns/100ps

module rs_entry (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic                                      load,
  input  logic                                      flush,
  input  logic                                      issue,
  input  logic [rs_pkg::scalar-1:0]                 cdb_valid,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] cdb_tag,
  input  logic [rs_pkg::prf_idx-1:0]                prega_idx,
  input  logic [rs_pkg::prf_idx-1:0]                pregb_idx,
  input  logic [rs_pkg::prf_idx-1:0]                pdest_idx,
  input  logic                                      prega_valid,
  input  logic                                      pregb_valid,
  input  logic [rs_pkg::op_w-1:0]                   alu_op,
  input  logic                                      rd_mem,
  input  logic                                      wr_mem,
  input  logic [rs_pkg::ir_w-1:0]                   rs_ir,
  input  logic [rs_pkg::pc_w-1:0]                   npc,
  input  logic                                      cond_branch,
  input  logic                                      uncond_branch,
  input  logic [rs_pkg::rob_idx-1:0]                rob_idx,
  input  logic [rs_pkg::lsq_idx-1:0]                lsq_idx,
  output logic                                      busy,
  output logic                                      ready,
  output logic [rs_pkg::cls_w-1:0]                  fu_class,
  output logic [rs_pkg::prf_idx-1:0]                prega_q,
  output logic [rs_pkg::prf_idx-1:0]                pregb_q,
  output logic [rs_pkg::prf_idx-1:0]                pdest_q,
  output logic [rs_pkg::op_w-1:0]                   alu_op_q,
  output logic                                      rd_mem_q,
  output logic                                      wr_mem_q,
  output logic [rs_pkg::ir_w-1:0]                   rs_ir_q,
  output logic [rs_pkg::pc_w-1:0]                   npc_q,
  output logic                                      cond_branch_q,
  output logic                                      uncond_branch_q,
  output logic [rs_pkg::rob_idx-1:0]                rob_idx_q,
  output logic [rs_pkg::lsq_idx-1:0]                lsq_idx_q
);

  logic a_rdy;
  logic b_rdy;

  // Tag seen on either broadcast this cycle
  function automatic logic cdb_hit(input logic [rs_pkg::prf_idx-1:0] tag);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < rs_pkg::scalar; i++) begin
      if (cdb_valid[i] && cdb_tag[i*rs_pkg::prf_idx +: rs_pkg::prf_idx] == tag) hit = 1'b1;
    end
    return hit;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy  <= 1'b0;
      a_rdy <= 1'b0;
      b_rdy <= 1'b0;
    end else if (flush) begin
      busy <= 1'b0;
    end else if (load) begin
      busy  <= 1'b1;
      a_rdy <= prega_valid | cdb_hit(prega_idx);  // Catch a broadcast in the load cycle
      b_rdy <= pregb_valid | cdb_hit(pregb_idx);
    end else begin
      if (issue) busy <= 1'b0;
      a_rdy <= a_rdy | cdb_hit(prega_q);
      b_rdy <= b_rdy | cdb_hit(pregb_q);
    end
  end

  always_ff @(posedge clk) begin
    if (load && !flush) begin
      prega_q         <= prega_idx;
      pregb_q         <= pregb_idx;
      pdest_q         <= pdest_idx;
      alu_op_q        <= alu_op;
      rd_mem_q        <= rd_mem;
      wr_mem_q        <= wr_mem;
      rs_ir_q         <= rs_ir;
      npc_q           <= npc;
      cond_branch_q   <= cond_branch;
      uncond_branch_q <= uncond_branch;
      rob_idx_q       <= rob_idx;
      lsq_idx_q       <= lsq_idx;
    end
  end

  assign ready    = busy & a_rdy & b_rdy;
  assign fu_class = rs_pkg::fu_class_of(alu_op_q, rd_mem_q, wr_mem_q);

endmodule

/* logic/rs_select.sv */
`timescale 1ns/100ps

module rs_select (
  input  logic [rs_pkg::rs_sz-1:0]                   ready,
  input  logic [rs_pkg::rs_sz-1:0][rs_pkg::cls_w-1:0] entry_class,
  input  logic                                       ex_free,
  input  logic                                       mem_free,
  input  logic                                       mult_free,
  output logic [rs_pkg::rs_sz-1:0]                   issue_hot,
  output logic [rs_pkg::rs_idx-1:0]                  issue_idx,
  output logic                                       issue_en,
  output logic [rs_pkg::cls_w-1:0]                   issue_class
);

  logic [rs_pkg::rs_sz-1:0] cand;

  // Ready slots whose class has a unit this cycle
  always_comb begin
    for (int i = 0; i < rs_pkg::rs_sz; i++) begin
      case (entry_class[i])
        rs_pkg::cls_mem:  cand[i] = ready[i] & mem_free;
        rs_pkg::cls_mult: cand[i] = ready[i] & mult_free;
        default:          cand[i] = ready[i] & ex_free;
      endcase
    end
  end

  // Lowest index wins
  always_comb begin
    issue_hot = '0;
    issue_idx = '0;
    for (int i = rs_pkg::rs_sz-1; i >= 0; i--) begin
      if (cand[i]) begin
        issue_hot    = '0;
        issue_hot[i] = 1'b1;
        issue_idx    = rs_pkg::rs_idx'(i);
      end
    end
  end

  assign issue_en    = |cand;
  assign issue_class = entry_class[issue_idx];

endmodule

/* logic/rs.sv */
`timescale 1ns/100ps

module rs (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic                                      en,
  input  logic [rs_pkg::prf_idx-1:0]                prega_idx,
  input  logic [rs_pkg::prf_idx-1:0]                pregb_idx,
  input  logic [rs_pkg::prf_idx-1:0]                pdest_idx,
  input  logic                                      prega_valid,
  input  logic                                      pregb_valid,
  input  logic [rs_pkg::op_w-1:0]                   alu_op,
  input  logic                                      rd_mem,
  input  logic                                      wr_mem,
  input  logic [rs_pkg::ir_w-1:0]                   rs_ir,
  input  logic [rs_pkg::pc_w-1:0]                   npc,
  input  logic                                      cond_branch,
  input  logic                                      uncond_branch,
  input  logic [rs_pkg::rob_idx-1:0]                rob_idx,
  input  logic [rs_pkg::lsq_idx-1:0]                lsq_idx,
  input  logic                                      ex_free,
  input  logic                                      mem_free,
  input  logic                                      mult_free,
  input  logic [rs_pkg::scalar-1:0]                 cdb_valid,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] cdb_tag,
  input  logic [rs_pkg::rs_sz-1:0]                  entry_flush,
  output logic                                      rs_free,
  output logic                                      alu_rdy,
  output logic                                      mem_rdy,
  output logic                                      mult_rdy,
  output logic                                      en_out,
  output logic [rs_pkg::rs_idx-1:0]                 rs_idx_out,
  output logic [rs_pkg::cls_w-1:0]                  issue_class,
  output logic [rs_pkg::prf_idx-1:0]                pdest_idx_out,
  output logic [rs_pkg::prf_idx-1:0]                prega_idx_out,
  output logic [rs_pkg::prf_idx-1:0]                pregb_idx_out,
  output logic [rs_pkg::op_w-1:0]                   alu_op_out,
  output logic                                      rd_mem_out,
  output logic                                      wr_mem_out,
  output logic [rs_pkg::ir_w-1:0]                   rs_ir_out,
  output logic [rs_pkg::pc_w-1:0]                   npc_out,
  output logic                                      cond_branch_out,
  output logic                                      uncond_branch_out,
  output logic [rs_pkg::rob_idx-1:0]                rob_idx_out,
  output logic [rs_pkg::lsq_idx-1:0]                lsq_idx_out
);

  logic [rs_pkg::rs_sz-1:0]                     busy;
  logic [rs_pkg::rs_sz-1:0]                     ready;
  logic [rs_pkg::rs_sz-1:0]                     load;
  logic [rs_pkg::rs_sz-1:0]                     issue_hot;
  logic [rs_pkg::rs_sz-1:0][rs_pkg::cls_w-1:0]  cls;
  logic [rs_pkg::rs_sz-1:0][rs_pkg::prf_idx-1:0] e_prega;
  logic [rs_pkg::rs_sz-1:0][rs_pkg::prf_idx-1:0] e_pregb;
  logic [rs_pkg::rs_sz-1:0][rs_pkg::prf_idx-1:0] e_pdest;
  logic [rs_pkg::rs_sz-1:0][rs_pkg::op_w-1:0]   e_op;
  logic [rs_pkg::rs_sz-1:0]                     e_rd;
  logic [rs_pkg::rs_sz-1:0]                     e_wr;
  logic [rs_pkg::rs_sz-1:0][rs_pkg::ir_w-1:0]   e_ir;
  logic [rs_pkg::rs_sz-1:0][rs_pkg::pc_w-1:0]   e_npc;
  logic [rs_pkg::rs_sz-1:0]                     e_cbr;
  logic [rs_pkg::rs_sz-1:0]                     e_ubr;
  logic [rs_pkg::rs_sz-1:0][rs_pkg::rob_idx-1:0] e_rob;
  logic [rs_pkg::rs_sz-1:0][rs_pkg::lsq_idx-1:0] e_lsq;

  // First empty slot takes the new instruction
  always_comb begin
    load = '0;
    for (int i = rs_pkg::rs_sz-1; i >= 0; i--) begin
      if (!busy[i]) begin
        load    = '0;
        load[i] = en;
      end
    end
  end

  assign rs_free = ~&busy;

  // Class readiness ignoring units, used by the top for sharing
  always_comb begin
    alu_rdy  = 1'b0;
    mem_rdy  = 1'b0;
    mult_rdy = 1'b0;
    for (int i = 0; i < rs_pkg::rs_sz; i++) begin
      if (ready[i]) begin
        case (cls[i])
          rs_pkg::cls_mem:  mem_rdy  = 1'b1;
          rs_pkg::cls_mult: mult_rdy = 1'b1;
          default:          alu_rdy  = 1'b1;
        endcase
      end
    end
  end

  for (genvar i = 0; i < rs_pkg::rs_sz; i++) begin : g_entry
    rs_entry u_entry (
      .clk,
      .arst_n,
      .load            (load[i]),
      .flush           (entry_flush[i]),
      .issue           (issue_hot[i]),
      .cdb_valid,
      .cdb_tag,
      .prega_idx,
      .pregb_idx,
      .pdest_idx,
      .prega_valid,
      .pregb_valid,
      .alu_op,
      .rd_mem,
      .wr_mem,
      .rs_ir,
      .npc,
      .cond_branch,
      .uncond_branch,
      .rob_idx,
      .lsq_idx,
      .busy            (busy[i]),
      .ready           (ready[i]),
      .fu_class        (cls[i]),
      .prega_q         (e_prega[i]),
      .pregb_q         (e_pregb[i]),
      .pdest_q         (e_pdest[i]),
      .alu_op_q        (e_op[i]),
      .rd_mem_q        (e_rd[i]),
      .wr_mem_q        (e_wr[i]),
      .rs_ir_q         (e_ir[i]),
      .npc_q           (e_npc[i]),
      .cond_branch_q   (e_cbr[i]),
      .uncond_branch_q (e_ubr[i]),
      .rob_idx_q       (e_rob[i]),
      .lsq_idx_q       (e_lsq[i])
    );
  end

  rs_select u_select (
    .ready       (ready),
    .entry_class (cls),
    .ex_free     (ex_free),
    .mem_free    (mem_free),
    .mult_free   (mult_free),
    .issue_hot   (issue_hot),
    .issue_idx   (rs_idx_out),
    .issue_en    (en_out),
    .issue_class (issue_class)
  );

  assign pdest_idx_out     = e_pdest[rs_idx_out];
  assign prega_idx_out     = e_prega[rs_idx_out];
  assign pregb_idx_out     = e_pregb[rs_idx_out];
  assign alu_op_out        = e_op[rs_idx_out];
  assign rd_mem_out        = e_rd[rs_idx_out];
  assign wr_mem_out        = e_wr[rs_idx_out];
  assign rs_ir_out         = e_ir[rs_idx_out];
  assign npc_out           = e_npc[rs_idx_out];
  assign cond_branch_out   = e_cbr[rs_idx_out];
  assign uncond_branch_out = e_ubr[rs_idx_out];
  assign rob_idx_out       = e_rob[rs_idx_out];
  assign lsq_idx_out       = e_lsq[rs_idx_out];

endmodule

/* logic/super_rs.sv */
`timescale 1ns/100ps

module super_rs (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic [rs_pkg::scalar-1:0]                 inst_valid,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] prega_idx,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] pregb_idx,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] pdest_idx,
  input  logic [rs_pkg::scalar-1:0]                 prega_valid,
  input  logic [rs_pkg::scalar-1:0]                 pregb_valid,
  input  logic [rs_pkg::scalar*rs_pkg::op_w-1:0]    alu_op,
  input  logic [rs_pkg::scalar-1:0]                 rd_mem,
  input  logic [rs_pkg::scalar-1:0]                 wr_mem,
  input  logic [rs_pkg::scalar*rs_pkg::ir_w-1:0]    rs_ir,
  input  logic [rs_pkg::scalar*rs_pkg::pc_w-1:0]    npc,
  input  logic [rs_pkg::scalar-1:0]                 cond_branch,
  input  logic [rs_pkg::scalar-1:0]                 uncond_branch,
  input  logic [rs_pkg::scalar*rs_pkg::rob_idx-1:0] rob_idx,
  input  logic [rs_pkg::scalar*rs_pkg::lsq_idx-1:0] lsq_idx,
  input  logic [rs_pkg::scalar-1:0]                 multfu_free,
  input  logic [rs_pkg::scalar-1:0]                 exfu_free,
  input  logic [rs_pkg::scalar-1:0]                 memfu_free,
  input  logic [rs_pkg::scalar-1:0]                 cdb_valid,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] cdb_tag,
  input  logic [rs_pkg::scalar*rs_pkg::rs_sz-1:0]   entry_flush,
  output logic [rs_pkg::scalar-1:0]                 rs_stall,
  output logic [rs_pkg::scalar-1:0]                 en_out,
  output logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] pdest_idx_out,
  output logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] prega_idx_out,
  output logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] pregb_idx_out,
  output logic [rs_pkg::scalar*rs_pkg::op_w-1:0]    alu_op_out,
  output logic [rs_pkg::scalar-1:0]                 rd_mem_out,
  output logic [rs_pkg::scalar-1:0]                 wr_mem_out,
  output logic [rs_pkg::scalar*rs_pkg::ir_w-1:0]    rs_ir_out,
  output logic [rs_pkg::scalar*rs_pkg::pc_w-1:0]    npc_out,
  output logic [rs_pkg::scalar*rs_pkg::rob_idx-1:0] rob_idx_out,
  output logic [rs_pkg::scalar*rs_pkg::lsq_idx-1:0] lsq_idx_out,
  output logic [rs_pkg::scalar*rs_pkg::rs_idx-1:0]  rs_idx_out
);

  logic [rs_pkg::scalar-1:0] rs_free;
  logic [rs_pkg::scalar-1:0] alu_rdy;
  logic [rs_pkg::scalar-1:0] mem_rdy;
  logic [rs_pkg::scalar-1:0] mult_rdy;
  logic [rs_pkg::cls_w-1:0]  rs0_class;
  logic rs0_en;
  logic rs1_en;
  logic rs1_sel;
  logic rs0_ex_free;
  logic rs0_mem_free;
  logic rs0_mult_free;
  logic rs1_ex_free;
  logic rs1_mem_free;
  logic rs1_mult_free;
  logic rs0_to_ex;
  logic rs0_to_mem;
  logic rs0_to_mult;

  assign rs0_en   = rs_free[0] & inst_valid[0];
  assign rs1_sel  = rs_free[0];  // Lane 1 while bank 0 has room
  assign rs1_en   = rs_free[1] & (inst_valid[1] | (inst_valid[0] & ~rs_free[0]));
  assign rs_stall = ~rs_free;

  assign rs0_ex_free   = exfu_free[0] & alu_rdy[0];
  assign rs0_mem_free  = memfu_free[0] & mem_rdy[0];
  assign rs0_mult_free = multfu_free[0] & mult_rdy[0];

  // Bank 1 moves to unit 1 of a class only when bank 0 claims unit 0
  assign rs0_to_ex   = en_out[0] & (rs0_class == rs_pkg::cls_alu);
  assign rs0_to_mem  = en_out[0] & (rs0_class == rs_pkg::cls_mem);
  assign rs0_to_mult = en_out[0] & (rs0_class == rs_pkg::cls_mult);

  assign rs1_ex_free   = (rs0_to_ex ? exfu_free[1] : exfu_free[0]) & alu_rdy[1];
  assign rs1_mem_free  = (rs0_to_mem ? memfu_free[1] : memfu_free[0]) & mem_rdy[1];
  assign rs1_mult_free = (rs0_to_mult ? multfu_free[1] : multfu_free[0]) & mult_rdy[1];

  rs rs0 (
    .clk, .arst_n,
    .en                (rs0_en),
    .prega_idx         (prega_idx[0 +: rs_pkg::prf_idx]),
    .pregb_idx         (pregb_idx[0 +: rs_pkg::prf_idx]),
    .pdest_idx         (pdest_idx[0 +: rs_pkg::prf_idx]),
    .prega_valid       (prega_valid[0]),
    .pregb_valid       (pregb_valid[0]),
    .alu_op            (alu_op[0 +: rs_pkg::op_w]),
    .rd_mem            (rd_mem[0]),
    .wr_mem            (wr_mem[0]),
    .rs_ir             (rs_ir[0 +: rs_pkg::ir_w]),
    .npc               (npc[0 +: rs_pkg::pc_w]),
    .cond_branch       (cond_branch[0]),
    .uncond_branch     (uncond_branch[0]),
    .rob_idx           (rob_idx[0 +: rs_pkg::rob_idx]),
    .lsq_idx           (lsq_idx[0 +: rs_pkg::lsq_idx]),
    .ex_free           (rs0_ex_free),
    .mem_free          (rs0_mem_free),
    .mult_free         (rs0_mult_free),
    .cdb_valid, .cdb_tag,
    .entry_flush       (entry_flush[0 +: rs_pkg::rs_sz]),
    .rs_free           (rs_free[0]),
    .alu_rdy           (alu_rdy[0]),
    .mem_rdy           (mem_rdy[0]),
    .mult_rdy          (mult_rdy[0]),
    .en_out            (en_out[0]),
    .rs_idx_out        (rs_idx_out[0 +: rs_pkg::rs_idx]),
    .issue_class       (rs0_class),
    .pdest_idx_out     (pdest_idx_out[0 +: rs_pkg::prf_idx]),
    .prega_idx_out     (prega_idx_out[0 +: rs_pkg::prf_idx]),
    .pregb_idx_out     (pregb_idx_out[0 +: rs_pkg::prf_idx]),
    .alu_op_out        (alu_op_out[0 +: rs_pkg::op_w]),
    .rd_mem_out        (rd_mem_out[0]),
    .wr_mem_out        (wr_mem_out[0]),
    .rs_ir_out         (rs_ir_out[0 +: rs_pkg::ir_w]),
    .npc_out           (npc_out[0 +: rs_pkg::pc_w]),
    .cond_branch_out   (),
    .uncond_branch_out (),
    .rob_idx_out       (rob_idx_out[0 +: rs_pkg::rob_idx]),
    .lsq_idx_out       (lsq_idx_out[0 +: rs_pkg::lsq_idx])
  );

  // Lane 0 spills into bank 1 once bank 0 is full
  rs rs1 (
    .clk, .arst_n,
    .en                (rs1_en),
    .prega_idx         (prega_idx[rs1_sel*rs_pkg::prf_idx +: rs_pkg::prf_idx]),
    .pregb_idx         (pregb_idx[rs1_sel*rs_pkg::prf_idx +: rs_pkg::prf_idx]),
    .pdest_idx         (pdest_idx[rs1_sel*rs_pkg::prf_idx +: rs_pkg::prf_idx]),
    .prega_valid       (prega_valid[rs1_sel]),
    .pregb_valid       (pregb_valid[rs1_sel]),
    .alu_op            (alu_op[rs1_sel*rs_pkg::op_w +: rs_pkg::op_w]),
    .rd_mem            (rd_mem[rs1_sel]),
    .wr_mem            (wr_mem[rs1_sel]),
    .rs_ir             (rs_ir[rs1_sel*rs_pkg::ir_w +: rs_pkg::ir_w]),
    .npc               (npc[rs1_sel*rs_pkg::pc_w +: rs_pkg::pc_w]),
    .cond_branch       (cond_branch[rs1_sel]),
    .uncond_branch     (uncond_branch[rs1_sel]),
    .rob_idx           (rob_idx[rs1_sel*rs_pkg::rob_idx +: rs_pkg::rob_idx]),
    .lsq_idx           (lsq_idx[rs1_sel*rs_pkg::lsq_idx +: rs_pkg::lsq_idx]),
    .ex_free           (rs1_ex_free),
    .mem_free          (rs1_mem_free),
    .mult_free         (rs1_mult_free),
    .cdb_valid, .cdb_tag,
    .entry_flush       (entry_flush[rs_pkg::rs_sz +: rs_pkg::rs_sz]),
    .rs_free           (rs_free[1]),
    .alu_rdy           (alu_rdy[1]),
    .mem_rdy           (mem_rdy[1]),
    .mult_rdy          (mult_rdy[1]),
    .en_out            (en_out[1]),
    .rs_idx_out        (rs_idx_out[rs_pkg::rs_idx +: rs_pkg::rs_idx]),
    .issue_class       (),
    .pdest_idx_out     (pdest_idx_out[rs_pkg::prf_idx +: rs_pkg::prf_idx]),
    .prega_idx_out     (prega_idx_out[rs_pkg::prf_idx +: rs_pkg::prf_idx]),
    .pregb_idx_out     (pregb_idx_out[rs_pkg::prf_idx +: rs_pkg::prf_idx]),
    .alu_op_out        (alu_op_out[rs_pkg::op_w +: rs_pkg::op_w]),
    .rd_mem_out        (rd_mem_out[1]),
    .wr_mem_out        (wr_mem_out[1]),
    .rs_ir_out         (rs_ir_out[rs_pkg::ir_w +: rs_pkg::ir_w]),
    .npc_out           (npc_out[rs_pkg::pc_w +: rs_pkg::pc_w]),
    .cond_branch_out   (),
    .uncond_branch_out (),
    .rob_idx_out       (rob_idx_out[rs_pkg::rob_idx +: rs_pkg::rob_idx]),
    .lsq_idx_out       (lsq_idx_out[rs_pkg::lsq_idx +: rs_pkg::lsq_idx])
  );

endmodule

/* verification/super_rs_asserts.sv */
`timescale 1ns/100ps

module super_rs_asserts (
  input logic                                   clk,
  input logic                                   arst_n,
  input logic [rs_pkg::scalar-1:0]              en_out,
  input logic [rs_pkg::scalar-1:0]              rs_stall,
  input logic [rs_pkg::scalar-1:0]              exfu_free,
  input logic [rs_pkg::scalar-1:0]              memfu_free,
  input logic [rs_pkg::scalar-1:0]              multfu_free,
  input logic [rs_pkg::scalar*rs_pkg::op_w-1:0] alu_op_out,
  input logic [rs_pkg::scalar-1:0]              rd_mem_out,
  input logic [rs_pkg::scalar-1:0]              wr_mem_out
);

  int err_count = 0;  // Polled by the testbench
  logic [1:0] c0;
  logic [1:0] c1;

  // 0 ALU, 1 memory, 2 multiply
  function automatic logic [1:0] class_of(input logic [4:0] op, input logic rd, input logic wr);
    if (rd || wr) return 2'd1;
    if (op == rs_pkg::op_mult) return 2'd2;
    return 2'd0;
  endfunction

  function automatic logic unit_free(input logic [1:0] c, input logic [1:0] ex,
                                     input logic [1:0] mem, input logic [1:0] mult,
                                     input int u);
    if (c == 2'd1) return mem[u];
    if (c == 2'd2) return mult[u];
    return ex[u];
  endfunction

  assign c0 = class_of(alu_op_out[4:0], rd_mem_out[0], wr_mem_out[0]);
  assign c1 = class_of(alu_op_out[9:5], rd_mem_out[1], wr_mem_out[1]);

  a_in_reset: assert property (@(posedge clk) !arst_n |-> (en_out == '0 && rs_stall == '0))
    else begin $error("issue or stall during reset"); err_count++; end

  a_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> (en_out == '0 && rs_stall == '0))
    else begin $error("issue or stall right after reset"); err_count++; end

  a_bank0_unit: assert property (@(posedge clk) disable iff (!arst_n)
      en_out[0] |-> unit_free(c0, exfu_free, memfu_free, multfu_free, 0))
    else begin $error("bank 0 issued without a free unit"); err_count++; end

  a_bank1_unit: assert property (@(posedge clk) disable iff (!arst_n)
      en_out[1] |-> unit_free(c1, exfu_free, memfu_free, multfu_free,
                              (en_out[0] && c0 == c1) ? 1 : 0))
    else begin $error("bank 1 issued without its shared unit"); err_count++; end

  a_dual_same: assert property (@(posedge clk) disable iff (!arst_n)
      (en_out == 2'b11 && c0 == c1) |->
      (unit_free(c0, exfu_free, memfu_free, multfu_free, 0) &&
       unit_free(c0, exfu_free, memfu_free, multfu_free, 1)))
    else begin $error("two same-class issues without two free units"); err_count++; end

endmodule

/* verification/super_rs_tb.sv */
`timescale 1ns/100ps

module super_rs_tb;

  localparam int n_inst    = 200;
  localparam int cyc_limit = 40 * (n_inst + 20);

  logic clk;
  logic arst_n;
  logic [1:0]   inst_valid;
  logic [11:0]  prega_idx, pregb_idx, pdest_idx;
  logic [1:0]   prega_valid, pregb_valid, rd_mem, wr_mem, cond_branch, uncond_branch;
  logic [9:0]   alu_op;
  logic [63:0]  rs_ir;
  logic [127:0] npc;
  logic [9:0]   rob_idx;
  logic [5:0]   lsq_idx;
  logic [1:0]   multfu_free, exfu_free, memfu_free, cdb_valid;
  logic [11:0]  cdb_tag;
  logic [15:0]  entry_flush;
  logic [1:0]   rs_stall, en_out, rd_mem_out, wr_mem_out;
  logic [11:0]  pdest_idx_out, prega_idx_out, pregb_idx_out;
  logic [9:0]   alu_op_out, rob_idx_out;
  logic [63:0]  rs_ir_out;
  logic [127:0] npc_out;
  logic [5:0]   lsq_idx_out, rs_idx_out;

  logic [31:0] lfsr = 32'h4d86_c1b5;
  logic [5:0] exp_a[n_inst], exp_b[n_inst], exp_dst[n_inst];
  logic [4:0] exp_op[n_inst];
  logic [2:0] exp_lsq[n_inst];
  bit a_vld[n_inst], b_vld[n_inst], a_seen[n_inst], b_seen[n_inst];
  bit mem_rd[n_inst], mem_wr[n_inst], issued[n_inst], flushed[n_inst];
  int exp_bank[n_inst];
  bit model_busy[2][8];
  int model_ser[2][8];
  int next_serial = 0;
  int cyc = 0;

  super_rs dut0 (.*);
  bind super_rs super_rs_asserts u_asserts (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] take(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (exp !== got) begin
      abort_run($sformatf("Fail t=%0t %s expected %0h got %0h", $time, name, exp, got));
    end
  endtask

  function automatic bit any_busy();
    for (int b = 0; b < 2; b++)
      for (int i = 0; i < 8; i++) if (model_busy[b][i]) return 1'b1;
    return 1'b0;
  endfunction

  task automatic check_issue(input int b);
    int s;
    int idx;
    s   = int'(npc_out[b*64 +: 16]);
    idx = int'(rs_idx_out[b*3 +: 3]);
    if (s >= n_inst) abort_run($sformatf("Bank %0d issued an unknown serial %0d", b, s));
    if (issued[s]) abort_run($sformatf("Serial %0d issued twice", s));
    if (flushed[s]) abort_run($sformatf("Flushed serial %0d issued", s));
    if (!model_busy[b][idx] || model_ser[b][idx] != s)
      abort_run($sformatf("Bank %0d slot %0d does not hold serial %0d", b, idx, s));
    check_value("npc_out", 64'(s), npc_out[b*64 +: 64]);
    check_value("rob_idx_out", 64'(s[4:0]), 64'(rob_idx_out[b*5 +: 5]));
    check_value("pdest_idx_out", 64'(exp_dst[s]), 64'(pdest_idx_out[b*6 +: 6]));
    check_value("rs_ir_out", 64'(exp_dst[s]), 64'(rs_ir_out[b*32 +: 32]));
    check_value("prega_idx_out", 64'(exp_a[s]), 64'(prega_idx_out[b*6 +: 6]));
    check_value("pregb_idx_out", 64'(exp_b[s]), 64'(pregb_idx_out[b*6 +: 6]));
    check_value("alu_op_out", 64'(exp_op[s]), 64'(alu_op_out[b*5 +: 5]));
    check_value("rd_mem_out", 64'(mem_rd[s]), 64'(rd_mem_out[b]));
    check_value("wr_mem_out", 64'(mem_wr[s]), 64'(wr_mem_out[b]));
    check_value("lsq_idx_out", 64'(exp_lsq[s]), 64'(lsq_idx_out[b*3 +: 3]));
    check_value("issue bank", 64'(exp_bank[s]), 64'(b));
    if (!a_seen[s] || !b_seen[s])
      abort_run($sformatf("Serial %0d issued with a source not ready", s));
    issued[s] = 1'b1;
  endtask

  initial begin
    int acc_bank;
    int acc_slot;
    int fb;
    int fs;
    int s;
    int missing;
    bit fl_do;
    arst_n = 1'b0;
    {inst_valid, prega_idx, pregb_idx, pdest_idx, prega_valid, pregb_valid} = '0;
    {alu_op, rd_mem, wr_mem, rs_ir, npc, cond_branch, uncond_branch} = '0;
    {rob_idx, lsq_idx, multfu_free, exfu_free, memfu_free, cdb_valid, cdb_tag} = '0;
    entry_flush = '0;
    for (int i = 0; i < n_inst; i++) begin
      exp_a[i]   = take(6);
      exp_b[i]   = take(6);
      exp_dst[i] = take(6);
      a_vld[i]   = take(1);
      b_vld[i]   = take(1);
      exp_op[i]  = take(1) ? rs_pkg::op_mult : take(5);
      mem_rd[i]  = (take(2) == 0);
      mem_wr[i]  = (take(3) == 0);
      exp_lsq[i] = take(3);
    end
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    while (next_serial < n_inst || any_busy()) begin
      @(negedge clk);
      s = next_serial;
      // Lane 1 carries a decoy and is raised only while bank 0 is full
      inst_valid = '0;
      if (s < n_inst && take(2) != 0) inst_valid = (rs_stall[0] && take(1)) ? 2'b11 : 2'b01;
      if (s < n_inst) begin
        prega_idx   = {6'h3f, exp_a[s]};
        pregb_idx   = {6'h3f, exp_b[s]};
        pdest_idx   = {6'h3f, exp_dst[s]};
        prega_valid = {1'b1, a_vld[s]};
        pregb_valid = {1'b1, b_vld[s]};
        alu_op      = {5'h00, exp_op[s]};
        rd_mem      = {1'b0, mem_rd[s]};
        wr_mem      = {1'b0, mem_wr[s]};
        rs_ir       = {32'hffff_ffff, 32'(exp_dst[s])};
        npc         = {64'hffff_ffff_ffff_ffff, 64'(s)};
        rob_idx     = {5'h1f, s[4:0]};
        lsq_idx     = {3'h7, exp_lsq[s]};
      end
      exfu_free = cyc < 40 ? '0 : take(2);  // Hold units busy early so the banks fill
      memfu_free = cyc < 40 ? '0 : take(2);
      multfu_free = cyc < 40 ? '0 : take(2);
      cdb_valid = take(2);
      cdb_tag = take(12);
      fl_do = (take(4) == 0);
      fb = take(1);
      fs = take(3);
      fl_do = fl_do && model_busy[fb][fs];
      entry_flush = '0;
      if (fl_do) entry_flush[fb*8 + fs] = 1'b1;
      #1;
      if (dut0.u_asserts.err_count != 0) abort_run("A concurrent assertion failed");
      for (int b = 0; b < 2; b++) if (en_out[b]) check_issue(b);
      acc_bank = -1;
      if (inst_valid[0] && !rs_stall[0]) acc_bank = 0;
      else if (inst_valid[0] && rs_stall[0] && !rs_stall[1]) acc_bank = 1;
      acc_slot = -1;
      if (acc_bank >= 0)
        for (int i = 7; i >= 0; i--) if (!model_busy[acc_bank][i]) acc_slot = i;
      for (int b = 0; b < 2; b++) if (en_out[b]) model_busy[b][rs_idx_out[b*3 +: 3]] = 1'b0;
      if (fl_do) begin
        flushed[model_ser[fb][fs]] = 1'b1;
        model_busy[fb][fs] = 1'b0;
      end
      if (acc_bank >= 0) begin
        model_busy[acc_bank][acc_slot] = 1'b1;
        model_ser[acc_bank][acc_slot] = s;
        exp_bank[s] = acc_bank;
        a_seen[s] = a_vld[s];
        b_seen[s] = b_vld[s];
        next_serial++;
      end
      for (int b = 0; b < 2; b++)
        for (int i = 0; i < 8; i++)
          for (int k = 0; k < 2; k++)
            if (model_busy[b][i] && cdb_valid[k]) begin
              if (cdb_tag[k*6 +: 6] == exp_a[model_ser[b][i]]) a_seen[model_ser[b][i]] = 1'b1;
              if (cdb_tag[k*6 +: 6] == exp_b[model_ser[b][i]]) b_seen[model_ser[b][i]] = 1'b1;
            end
      cyc++;
      if (cyc > cyc_limit) abort_run("Timeout: instructions still waiting at the cycle limit");
    end
    @(negedge clk);
    {inst_valid, cdb_valid, entry_flush} = '0;
    repeat (2) @(negedge clk);
    missing = 0;
    for (int i = 0; i < n_inst; i++) if (!issued[i] && !flushed[i]) missing++;
    if (missing != 0 || dut0.u_asserts.err_count != 0) begin
      abort_run($sformatf("%0d instructions never issued or an assertion failed", missing));
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

/* verilog.f */
logic/rs_pkg.sv
logic/rs_entry.sv
logic/rs_select.sv
logic/rs.sv
logic/super_rs.sv
verification/super_rs_asserts.sv
verification/super_rs_tb.sv
